// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it and judge the result from its log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_tag_cfg -f tag_cfg.f -o sim_tag_cfg \
   || { echo "build failed"; exit 1; }

# a run that aborts on its own counts as failing
./obj_dir/sim_tag_cfg > sim.log 2>&1 || echo "RESULT: FAIL" >> sim.log
cat sim.log

grep -q "RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; } \
   || echo "simulation passed"
exit 0

// ==== tag_cfg.f ====
tag_cfg_pkg.sv
tag_launch_sync.sv
tag_client.sv
tag_master.sv
tag_cfg_top.sv
tb_tag_cfg.sv

// ==== tag_cfg_pkg.sv ====
`default_nettype none

package tag_cfg_pkg;

   // width of one client configuration word
   localparam int cfg_width = 8;

   // number of clients hanging off the master
   localparam int num_clients = 2;

   typedef logic [cfg_width-1:0] cfg_data_t;

   // wide enough to name every client
   typedef logic [$clog2(num_clients)-1:0] client_id_t;

   // per-client serial bus
   // op=1           shift param in
   // op=0 param=1   reset operation
   // op=0 param=0   no-op
   // en gates the recv side, driven from the top
   typedef struct packed {
      logic op;
      logic param;
      logic en;
   } tag_bus_t;

   typedef enum logic {
      cmd_write = 1'b0,
      cmd_reset = 1'b1
   } tag_cmd_kind_e;

   // host command, 10 bits
   typedef struct packed {
      tag_cmd_kind_e kind;
      client_id_t    id;
      cfg_data_t     data;
   } tag_cmd_t;

   typedef enum logic [2:0] {
      st_idle   = 3'd0,
      st_reset  = 3'd1,
      st_shift  = 3'd2,
      st_settle = 3'd3,
      st_ack    = 3'd4
   } tag_master_state_e;

endpackage

`default_nettype wire

// ==== tag_cfg_top.sv ====
`default_nettype none

module tag_cfg_top
   #(
      parameter int unsigned            settle_cycles_p   = 12,
      parameter tag_cfg_pkg::cfg_data_t client0_default_p = '0,
      parameter tag_cfg_pkg::cfg_data_t client1_default_p = '0
   )
   (
      // tag domain, host side
      input  wire                         tag_clk_i,
      input  wire                         tag_reset_i,
      input  wire                         tag_en_i,
      input  wire                         cmd_req_i,
      input  wire tag_cfg_pkg::tag_cmd_t  cmd_i,
      output logic                        cmd_ack_o,

      // recv domain, client outputs
      input  wire                                  recv_clk_i,
      input  wire                                  recv_reset_i,
      output logic [tag_cfg_pkg::num_clients-1:0]  recv_new_o,
      output tag_cfg_pkg::cfg_data_t               recv_data0_o,
      output tag_cfg_pkg::cfg_data_t               recv_data1_o
   );

   import tag_cfg_pkg::*;

   // one serial bus per client
   tag_bus_t [num_clients-1:0] tag_bus;

   tag_master #(.settle_cycles_p(settle_cycles_p)) master
      (
         .tag_clk_i   (tag_clk_i),
         .tag_reset_i (tag_reset_i),
         .tag_en_i    (tag_en_i),
         .cmd_req_i   (cmd_req_i),
         .cmd_i       (cmd_i),
         .cmd_ack_o   (cmd_ack_o),
         .tag_o       (tag_bus)
      );

   tag_client #(.default_p(client0_default_p)) client0
      (
         .tag_clk_i    (tag_clk_i),
         .tag_i        (tag_bus[0]),
         .recv_clk_i   (recv_clk_i),
         .recv_reset_i (recv_reset_i),
         .recv_new_o   (recv_new_o[0]),
         .recv_data_o  (recv_data0_o)
      );

   tag_client #(.default_p(client1_default_p)) client1
      (
         .tag_clk_i    (tag_clk_i),
         .tag_i        (tag_bus[1]),
         .recv_clk_i   (recv_clk_i),
         .recv_reset_i (recv_reset_i),
         .recv_new_o   (recv_new_o[1]),
         .recv_data_o  (recv_data1_o)
      );

endmodule

`default_nettype wire

// ==== tag_client.sv ====
`default_nettype none

module tag_client
   #(
      parameter tag_cfg_pkg::cfg_data_t default_p = '0
   )
   (
      input  wire                      tag_clk_i,
      input  wire tag_cfg_pkg::tag_bus_t tag_i,

      input  wire                      recv_clk_i,
      // installs default_p, also usable without a working tag network
      input  wire                      recv_reset_i,
      output logic                     recv_new_o,
      output tag_cfg_pkg::cfg_data_t   recv_data_o
   );

   import tag_cfg_pkg::*;

   // send side, tag_clk_i domain
   logic      op_r;
   logic      op_r_r;
   logic      param_r;
   logic      reset_op;
   logic      shift_op;
   logic      no_op;
   logic      send_now;
   logic      tag_toggle;
   cfg_data_t tag_data_r;

   // bus is registered once before decode
   always_ff @(posedge tag_clk_i)
   begin
      op_r    <= tag_i.op;
      param_r <= tag_i.param;
      op_r_r  <= op_r;
   end

   assign reset_op = ~op_r & param_r;
   assign shift_op = op_r;
   assign no_op    = ~op_r & ~param_r;

   // last shift followed by a quiet cycle means the word is complete
   assign send_now = op_r_r & no_op;

   // lsb arrives first, so bits enter at the top and move down
   always_ff @(posedge tag_clk_i)
   begin
      if (shift_op)
         tag_data_r <= {param_r, tag_data_r[cfg_width-1:1]};
   end

   logic recv_toggle_n;

   // toggle flips once per send and crosses into the recv domain
   tag_launch_sync launch_sync
      (
         .tag_clk_i   (tag_clk_i),
         .tag_reset_i (reset_op),
         .toggle_i    (tag_toggle ^ send_now),
         .toggle_o    (tag_toggle),
         .recv_clk_i  (recv_clk_i),
         .sync_o      (recv_toggle_n)
      );

   // recv side, recv_clk_i domain
   logic      recv_toggle_r;
   logic      recv_new;
   logic      recv_new_r;
   logic      recv_new_r_r;
   logic      reset_r;
   cfg_data_t recv_data_r;

   // edge on the synchronized toggle, dropped while disconnected
   assign recv_new = (recv_toggle_r ^ recv_toggle_n) & tag_i.en;

   always_ff @(posedge recv_clk_i)
   begin
      // toggle history keeps tracking during reset so no stale edge survives it
      recv_toggle_r <= recv_toggle_n;
      reset_r       <= recv_reset_i;
      if (recv_reset_i)
      begin
         recv_new_r   <= 1'b0;
         recv_new_r_r <= 1'b0;
      end
      else
      begin
         recv_new_r   <= recv_new;
         // one extra pulse on the first cycle out of reset
         recv_new_r_r <= recv_new_r | reset_r;
      end
   end

   // shift register is quiet here, the master settles long enough
   always_ff @(posedge recv_clk_i)
   begin
      if (recv_reset_i)
         recv_data_r <= default_p;
      else if (recv_new_r)
         recv_data_r <= tag_data_r;
   end

   // en gating after the flop, so failsafe mode shows no pulses
   assign recv_new_o  = recv_new_r_r & tag_i.en;
   assign recv_data_o = recv_data_r;

   // flag needs en and lasts a single recv cycle
   a_new_single : assert property (@(posedge recv_clk_i) disable iff (recv_reset_i)
      recv_new_o |-> tag_i.en ##1 !recv_new_o);

   // output word only moves together with the flag or under reset
   a_data_stable : assert property (@(posedge recv_clk_i) disable iff (recv_reset_i)
      $changed(recv_data_o) |-> recv_new_o || $past(recv_reset_i));

endmodule

`default_nettype wire

// ==== tag_launch_sync.sv ====
`default_nettype none

module tag_launch_sync
   (
      input  wire  tag_clk_i,
      // driven by the tag reset operation, not by a host reset
      input  wire  tag_reset_i,
      input  wire  toggle_i,
      // launch flop output, fed back by the client to build the toggle
      output logic toggle_o,

      input  wire  recv_clk_i,
      output logic sync_o
   );

   logic launch_r;
   logic sync_r1;
   logic sync_r2;

   // launch flop in the tag domain
   // nothing combinational sits between this flop and the synchronizer
   always_ff @(posedge tag_clk_i)
   begin
      if (tag_reset_i)
         launch_r <= 1'b0;
      else
         launch_r <= toggle_i;
   end

   assign toggle_o = launch_r;

   // two-flop synchronizer in the recv domain
   // sync_r1 may go metastable, sync_r2 gives it a full recv cycle to settle
   always_ff @(posedge recv_clk_i)
   begin
      sync_r1 <= launch_r;
      sync_r2 <= sync_r1;
   end

   assign sync_o = sync_r2;

endmodule

`default_nettype wire

// ==== tag_master.sv ====
`default_nettype none

module tag_master
   #(
      parameter int unsigned settle_cycles_p = 12
   )
   (
      input  wire                         tag_clk_i,
      input  wire                         tag_reset_i,
      input  wire                         tag_en_i,

      // host command port, four-phase req/ack
      input  wire                         cmd_req_i,
      input  wire tag_cfg_pkg::tag_cmd_t  cmd_i,
      output logic                        cmd_ack_o,

      // one serial bus per client
      output tag_cfg_pkg::tag_bus_t [tag_cfg_pkg::num_clients-1:0] tag_o
   );

   import tag_cfg_pkg::*;

   // counter covers both the 8 shift bits and the settle phase
   localparam int unsigned cnt_max_lp   = (settle_cycles_p > 7) ? settle_cycles_p : 7;
   localparam int unsigned cnt_width_lp = $clog2(cnt_max_lp + 1);

   typedef logic [cnt_width_lp-1:0] cnt_t;

   tag_master_state_e            state_r;
   cnt_t                         cnt_r;
   logic                         ack_r;
   logic                         en_r;
   tag_cmd_t                     cmd_r;
   tag_bus_t [num_clients-1:0]   tag_r;
   tag_bus_t [num_clients-1:0]   tag_n;
   logic     [num_clients-1:0]   op_vec;

   // command is captured on the edge that accepts the request
   always_ff @(posedge tag_clk_i)
   begin
      if (state_r == st_idle && cmd_req_i)
         cmd_r <= cmd_i;
   end

   // next bus value, only the addressed client sees anything but no-op
   always_comb
   begin
      for (int i = 0; i < num_clients; i++)
         tag_n[i] = '{op: 1'b0, param: 1'b0, en: en_r};
      case (state_r)
         st_shift:
         begin
            tag_n[cmd_r.id].op    = 1'b1;
            tag_n[cmd_r.id].param = cmd_r.data[cnt_r[2:0]];
         end
         st_reset:
            tag_n[cmd_r.id].param = 1'b1;
         default:
         begin
         end
      endcase
   end

   always_ff @(posedge tag_clk_i)
   begin
      if (tag_reset_i)
      begin
         state_r <= st_idle;
         cnt_r   <= '0;
         ack_r   <= 1'b0;
         en_r    <= 1'b0;
         tag_r   <= '0;
      end
      else
      begin
         tag_r <= tag_n;
         case (state_r)
            st_idle:
            begin
               // en only follows the input between commands
               en_r  <= tag_en_i;
               cnt_r <= '0;
               if (cmd_req_i)
                  state_r <= (cmd_i.kind == cmd_write) ? st_shift : st_reset;
            end
            st_shift:
            begin
               cnt_r <= cnt_r + 1'b1;
               if (cnt_r == cnt_t'(7))
               begin
                  cnt_r   <= '0;
                  state_r <= st_settle;
               end
            end
            st_reset:
            begin
               // two reset-operation cycles
               cnt_r <= cnt_r + 1'b1;
               if (cnt_r == cnt_t'(1))
               begin
                  cnt_r   <= '0;
                  state_r <= st_settle;
               end
            end
            st_settle:
            begin
               // first no-op fires the client send, then the crossing gets
               // settle_cycles_p quiet cycles
               cnt_r <= cnt_r + 1'b1;
               if (cnt_r == cnt_t'(settle_cycles_p))
                  state_r <= st_ack;
            end
            st_ack:
            begin
               // hold ack until the host lets go of req
               if (!ack_r)
                  ack_r <= 1'b1;
               else if (!cmd_req_i)
               begin
                  ack_r   <= 1'b0;
                  state_r <= st_idle;
               end
            end
            default:
               state_r <= st_idle;
         endcase
      end
   end

   assign cmd_ack_o = ack_r;
   assign tag_o     = tag_r;

   always_comb
   begin
      for (int i = 0; i < num_clients; i++)
         op_vec[i] = tag_r[i].op;
   end

   // ack only answers a request that is still held
   a_ack_needs_req : assert property (@(posedge tag_clk_i) disable iff (tag_reset_i)
      $rose(cmd_ack_o) |-> $past(cmd_req_i));

   // never shift into two clients at once
   a_one_shift_bus : assert property (@(posedge tag_clk_i) disable iff (tag_reset_i)
      $onehot0(op_vec));

endmodule

`default_nettype wire

// ==== tb_tag_cfg.sv ====
`default_nettype none

module tb_tag_cfg;

   import tag_cfg_pkg::*;

   localparam int settle_lp = 12;
   localparam cfg_data_t default0_lp = 8'hA5;
   localparam cfg_data_t default1_lp = 8'h3C;
   localparam int tag_period_lp = 34;
   // 2 resets, 3 directed, 20 random, 2 while disconnected, 2 after reconnect
   localparam int num_cmds_lp = 29;
   localparam int watchdog_lp = (num_cmds_lp * (settle_lp + 12) + 400) * tag_period_lp;

   logic tag_clk_i = 1'b0;
   logic recv_clk_i = 1'b0;
   logic tag_reset_i;
   logic tag_en_i;
   logic cmd_req_i;
   tag_cmd_t cmd_i;
   logic cmd_ack_o;
   logic recv_reset_i;
   logic [num_clients-1:0] recv_new_o;
   cfg_data_t recv_data0_o;
   cfg_data_t recv_data1_o;

   // model state
   cfg_data_t exp_data [num_clients];
   cfg_data_t data_w [num_clients];
   int issued [num_clients];
   int seen [num_clients] = '{default: 0};
   int req_edges = 0;
   int exp_edges;
   logic en_on;
   logic en_quiet;
   integer seed;
   int tag_errors = 0;
   int recv_errors = 0;
   int seq_errors;

   always #17 tag_clk_i = ~tag_clk_i;
   always #10 recv_clk_i = ~recv_clk_i;

   tag_cfg_top #(
      .settle_cycles_p   (settle_lp),
      .client0_default_p (default0_lp),
      .client1_default_p (default1_lp)
   ) dut (
      .tag_clk_i    (tag_clk_i),
      .tag_reset_i  (tag_reset_i),
      .tag_en_i     (tag_en_i),
      .cmd_req_i    (cmd_req_i),
      .cmd_i        (cmd_i),
      .cmd_ack_o    (cmd_ack_o),
      .recv_clk_i   (recv_clk_i),
      .recv_reset_i (recv_reset_i),
      .recv_new_o   (recv_new_o),
      .recv_data0_o (recv_data0_o),
      .recv_data1_o (recv_data1_o)
   );

   assign data_w[0] = recv_data0_o;
   assign data_w[1] = recv_data1_o;

   // tag cycles from request to ack
   // 8 shift bits or 2 reset ops, one no-op that fires the send, settle, ack
   function automatic int req_to_ack(input tag_cmd_kind_e kind);
      return ((kind == cmd_write) ? 10 : 4) + settle_lp;
   endfunction

   // edges with req high and ack still low
   always @(posedge tag_clk_i)
   begin
      if (!cmd_req_i)
         req_edges <= 0;
      else if (!cmd_ack_o)
         req_edges <= req_edges + 1;
   end

   always @(posedge recv_clk_i)
   begin
      for (int k = 0; k < num_clients; k++)
         if (recv_new_o[k])
            seen[k] <= seen[k] + 1;
   end

   a_ack_after_req : assert property (@(posedge tag_clk_i) disable iff (tag_reset_i)
      $rose(cmd_ack_o) |-> $past(cmd_req_i))
   else
   begin
      tag_errors++;
      $display("at time %0t ack rose without a pending request", $time);
   end

   a_ack_holds : assert property (@(posedge tag_clk_i) disable iff (tag_reset_i)
      $fell(cmd_ack_o) |-> !$past(cmd_req_i))
   else
   begin
      tag_errors++;
      $display("at time %0t ack dropped while req was still high", $time);
   end

   // counter also holds the edge that sampled the request
   a_ack_latency : assert property (@(posedge tag_clk_i) disable iff (tag_reset_i)
      $rose(cmd_ack_o) |-> req_edges == exp_edges)
   else
   begin
      tag_errors++;
      $display("Error at time %0t: req_edges expected %0d got %0d",
         $time, exp_edges, $sampled(req_edges));
   end

   a_quiet_disabled : assert property (@(posedge recv_clk_i) disable iff (recv_reset_i)
      en_quiet |-> recv_new_o == '0)
   else
   begin
      recv_errors++;
      $display("Error at time %0t: recv_new_o expected 00 got %b", $time, $sampled(recv_new_o));
   end

   for (genvar k = 0; k < num_clients; k++)
   begin : client_checks
      // a pulse needs an outstanding write or reset exit for this client
      a_new_expected : assert property (@(posedge recv_clk_i) disable iff (recv_reset_i)
         recv_new_o[k] |-> seen[k] < issued[k])
      else
      begin
         recv_errors++;
         $display("Error at time %0t: recv_new_o[%0d] expected 0 got 1", $time, k);
      end

      a_new_data : assert property (@(posedge recv_clk_i) disable iff (recv_reset_i)
         recv_new_o[k] |-> data_w[k] == exp_data[k])
      else
      begin
         recv_errors++;
         $display("Error at time %0t: recv_data%0d_o expected %h got %h",
            $time, k, $sampled(exp_data[k]), $sampled(data_w[k]));
      end

      // nothing outstanding, so the word must sit still
      a_data_held : assert property (@(posedge recv_clk_i) disable iff (recv_reset_i)
         seen[k] == issued[k] |-> data_w[k] == exp_data[k])
      else
      begin
         recv_errors++;
         $display("Error at time %0t: recv_data%0d_o expected %h got %h while idle",
            $time, k, $sampled(exp_data[k]), $sampled(data_w[k]));
      end
   end

   task automatic check_pulse_counts();
      for (int k = 0; k < num_clients; k++)
         assert (seen[k] == issued[k])
         else
         begin
            seq_errors++;
            $display("Error at time %0t: recv_new_o[%0d] pulse count expected %0d got %0d",
               $time, k, issued[k], seen[k]);
         end
   endtask

   // full four-phase handshake for one command
   task automatic run_cmd(input tag_cmd_kind_e kind, input client_id_t id, input cfg_data_t data);
      logic [31:0] hold;
      @(posedge tag_clk_i);
      #1;
      cmd_i.kind = kind;
      cmd_i.id   = id;
      cmd_i.data = data;
      exp_edges  = req_to_ack(kind) + 1;
      if (kind == cmd_write && en_on)
      begin
         exp_data[id] = data;
         issued[id]   = issued[id] + 1;
      end
      cmd_req_i = 1'b1;
      while (!cmd_ack_o)
      begin
         @(posedge tag_clk_i);
         #1;
      end
      // host keeps req up 0 to 3 more cycles, ack has to stay with it
      hold = $random(seed);
      repeat (hold[1:0])
      begin
         @(posedge tag_clk_i);
         #1;
      end
      cmd_req_i = 1'b0;
      while (cmd_ack_o)
      begin
         @(posedge tag_clk_i);
         #1;
      end
   endtask

   // recv reset installs the defaults, one pulse per client follows if connected
   task automatic pulse_recv_reset();
      @(posedge recv_clk_i);
      #1;
      recv_reset_i = 1'b1;
      exp_data[0]  = default0_lp;
      exp_data[1]  = default1_lp;
      repeat (8) @(posedge recv_clk_i);
      #1;
      if (en_on)
         for (int k = 0; k < num_clients; k++)
            issued[k] = issued[k] + 1;
      recv_reset_i = 1'b0;
      repeat (6) @(posedge recv_clk_i);
      check_pulse_counts();
   endtask

   task automatic random_writes(input int count);
      logic [31:0] rnd;
      repeat (count)
      begin
         rnd = $random(seed);
         // idle gap of 0 to 3 tag cycles
         repeat (rnd[11:10]) @(posedge tag_clk_i);
         run_cmd(cmd_write, rnd[8], rnd[7:0]);
         check_pulse_counts();
      end
   endtask

   task automatic set_enable(input logic value);
      @(posedge tag_clk_i);
      #1;
      tag_en_i = value;
      en_on    = value;
      // master picks en up in idle, bus carries it one cycle later
      repeat (4) @(posedge tag_clk_i);
   endtask

   initial
   begin
      #(watchdog_lp);
      $display("watchdog expired before the test sequence finished");
      $display("RESULT: FAIL");
      $finish;
   end

   initial
   begin
      tag_reset_i  = 1'b1;
      recv_reset_i = 1'b1;
      tag_en_i     = 1'b1;
      cmd_req_i    = 1'b0;
      cmd_i        = '0;
      seed         = 88;
      seq_errors   = 0;
      en_on        = 1'b1;
      en_quiet     = 1'b0;
      exp_edges    = 0;
      exp_data[0]  = default0_lp;
      exp_data[1]  = default1_lp;
      issued[0]    = 0;
      issued[1]    = 0;
      repeat (8) @(posedge tag_clk_i);
      #1;
      tag_reset_i = 1'b0;

      // reset operation on each client first, then the recv side
      run_cmd(cmd_reset, 1'b0, '0);
      run_cmd(cmd_reset, 1'b1, '0);
      pulse_recv_reset();

      // single set bits show the LSB-first order
      run_cmd(cmd_write, 1'b0, 8'h01);
      check_pulse_counts();
      run_cmd(cmd_write, 1'b1, 8'h80);
      check_pulse_counts();
      run_cmd(cmd_write, 1'b0, 8'hC3);
      check_pulse_counts();

      random_writes(20);

      // disconnected, writes still complete but nothing reaches the outputs
      set_enable(1'b0);
      en_quiet = 1'b1;
      run_cmd(cmd_write, 1'b0, 8'hFF);
      run_cmd(cmd_write, 1'b1, 8'h00);
      check_pulse_counts();
      pulse_recv_reset();
      en_quiet = 1'b0;

      set_enable(1'b1);
      run_cmd(cmd_write, 1'b0, 8'h5A);
      check_pulse_counts();
      run_cmd(cmd_write, 1'b1, 8'hE7);
      check_pulse_counts();

      $display("errors: tag %0d recv %0d sequence %0d", tag_errors, recv_errors, seq_errors);
      if (tag_errors + recv_errors + seq_errors == 0)
         $display("RESULT: PASS");
      else
         $display("RESULT: FAIL");
      $finish;
   end

endmodule

`default_nettype wire
